// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Dynamixel master testbench with Verilator and runs it.
# The run counts as failed if the log holds the fail message.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dyna_ctrl -f sources.f -o tb_dyna_ctrl

# Concurrent assertion errors are counted by the testbench, so keep running past them
./obj_dir/tb_dyna_ctrl +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"

// ==== sources.f ====
src/dyna_pkg.sv
src/dyna_inst_sender.sv
src/dyna_status_receiver.sv
src/dyna_link_ctrl.sv
src/dyna_ctrl.sv
testbench/dyna_ctrl_checker.sv
testbench/tb_dyna_ctrl.sv

// ==== src/dyna_ctrl.sv ====
// Bus is split into ttl_out, ttl_oe and ttl_in, the board top adds the tri-state buffer
// and the pull-up. Defaults suit 50 MHz and 57600 baud
`timescale 1ns/1ps
`default_nettype none

module dyna_ctrl #(
  parameter int clks_per_bit     = 868,    // 50 MHz / 57600 baud
  parameter int rsp_timeout_clks = 50000   // 1 ms at 50 MHz
) (
  input  logic                 clk_fpga,
  input  logic                 rst_n,
  // Host side
  input  dyna_pkg::dyna_inst_t cmd,
  input  logic                 cmd_valid,
  output logic                 busy,
  output dyna_pkg::dyna_rsp_t  rsp,
  output logic                 rsp_valid,
  // Half duplex TTL bus
  output logic                 ttl_out,
  output logic                 ttl_oe,
  input  logic                 ttl_in
);

  import dyna_pkg::*;

  dyna_inst_t   tx_pkt;        // Latched command
  logic         tx_start;
  logic         tx_done;
  logic         rx_arm;        // Level, high while a status packet is expected
  dyna_status_t status;
  logic         status_valid;

  // ----------------------------------------
  // Sequencing and response
  // ----------------------------------------
  dyna_link_ctrl #(
    .rsp_timeout_clks (rsp_timeout_clks)
  ) link_ctrl_i (
    .clk_fpga     (clk_fpga),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .busy         (busy),
    .tx_pkt       (tx_pkt),
    .tx_start     (tx_start),
    .tx_done      (tx_done),
    .rx_arm       (rx_arm),
    .status       (status),
    .status_valid (status_valid),
    .rsp          (rsp),
    .rsp_valid    (rsp_valid)
  );

  // TX path, owns the bus while ttl_oe is high
  dyna_inst_sender #(
    .clks_per_bit (clks_per_bit)
  ) inst_sender_i (
    .clk_fpga (clk_fpga),
    .rst_n    (rst_n),
    .pkt      (tx_pkt),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .ttl_out  (ttl_out),
    .ttl_oe   (ttl_oe)
  );

  // RX path
  dyna_status_receiver #(
    .clks_per_bit (clks_per_bit)
  ) status_receiver_i (
    .clk_fpga     (clk_fpga),
    .rst_n        (rst_n),
    .rx_arm       (rx_arm),
    .ttl_in       (ttl_in),
    .status       (status),
    .status_valid (status_valid)
  );

endmodule

`default_nettype wire

// ==== src/dyna_inst_sender.sv ====
// 8N1, LSB first, bytes back to back with no idle gap between them
// pkt must hold still from tx_start until tx_done, tx_start is ignored while sending
`timescale 1ns/1ps
`default_nettype none

module dyna_inst_sender #(
  parameter int clks_per_bit = 868
) (
  input  logic                 clk_fpga,
  input  logic                 rst_n,
  input  dyna_pkg::dyna_inst_t pkt,
  input  logic                 tx_start,
  output logic                 tx_done,
  output logic                 ttl_out,
  output logic                 ttl_oe
);

  import dyna_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  // Field currently on the wire
  typedef enum logic [2:0] {
    fld_pre0, fld_pre1, fld_id, fld_len, fld_inst, fld_param, fld_csum
  } field_t;

  field_t           field, next_field;
  param_cnt_t       param_idx, next_idx;  // Parameter being sent / to send next
  logic [7:0]       next_byte;
  logic [7:0]       csum;                 // Running sum of id..params
  logic [9:0]       frame;                // Stop, data, start, shifted out from bit 0
  logic [3:0]       bit_cnt;              // 0 start, 1..8 data, 9 stop
  logic [cnt_w-1:0] baud_cnt;
  logic             bit_end;
  logic             byte_end;
  logic             add_to_sum;

  assign bit_end  = ttl_oe && (baud_cnt == cnt_w'(clks_per_bit - 1));
  assign byte_end = bit_end && (bit_cnt == 4'd9);
  assign ttl_out  = frame[0];  // Frame register idles all ones

  // ----------------------------------------
  // Byte selection
  // ----------------------------------------
  always_comb begin
    next_field = field;
    next_idx   = param_idx;
    case (field)
      fld_pre0: next_field = fld_pre1;
      fld_pre1: next_field = fld_id;
      fld_id:   next_field = fld_len;
      fld_len:  next_field = fld_inst;
      fld_inst: begin
        next_field = (pkt.param_count == '0) ? fld_csum : fld_param;  // Ping skips params
        next_idx   = '0;
      end
      fld_param: begin
        if (param_idx == pkt.param_count - param_cnt_t'(1)) begin
          next_field = fld_csum;
        end else begin
          next_idx = param_idx + param_cnt_t'(1);
        end
      end
      default: next_field = fld_csum;  // Checksum is the last byte
    endcase

    case (next_field)
      fld_id:    next_byte = pkt.id;
      fld_len:   next_byte = 8'(pkt.param_count) + 8'd2;
      fld_inst:  next_byte = pkt.inst;
      fld_param: next_byte = pkt.params[next_idx];
      fld_csum:  next_byte = ~csum;    // Inverted low byte of the sum
      default:   next_byte = preamble_byte;
    endcase
  end

  // Preamble and checksum stay out of the sum
  assign add_to_sum = (next_field == fld_id) || (next_field == fld_len) ||
                      (next_field == fld_inst) || (next_field == fld_param);

  // ----------------------------------------
  // Serializer
  // ----------------------------------------
  always_ff @(posedge clk_fpga or negedge rst_n) begin
    if (!rst_n) begin
      ttl_oe    <= 1'b0;
      tx_done   <= 1'b0;
      frame     <= '1;     // Idle line high
      field     <= fld_pre0;
      param_idx <= '0;
      csum      <= '0;
      bit_cnt   <= '0;
      baud_cnt  <= '0;
    end else begin
      tx_done <= 1'b0;
      if (!ttl_oe) begin
        if (tx_start) begin
          ttl_oe    <= 1'b1;                             // Start bit next cycle
          frame     <= {1'b1, preamble_byte, 1'b0};
          field     <= fld_pre0;
          param_idx <= '0;
          csum      <= '0;
          bit_cnt   <= '0;
          baud_cnt  <= '0;
        end
      end else if (byte_end) begin
        bit_cnt  <= '0;
        baud_cnt <= '0;
        if (field == fld_csum) begin
          ttl_oe  <= 1'b0;   // Release the bus after the last stop bit
          tx_done <= 1'b1;
        end else begin
          field     <= next_field;
          param_idx <= next_idx;
          frame     <= {1'b1, next_byte, 1'b0};
          if (add_to_sum) csum <= csum + next_byte;
        end
      end else if (bit_end) begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 4'd1;
        frame    <= {1'b1, frame[9:1]};  // Next bit, fill with idle level
      end else begin
        baud_cnt <= baud_cnt + cnt_w'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dyna_link_ctrl.sv ====
// One transaction at a time, cmd_valid while busy is dropped
// Timeout window starts the cycle after tx_done
`timescale 1ns/1ps
`default_nettype none

module dyna_link_ctrl #(
  parameter int rsp_timeout_clks = 50000
) (
  input  logic                   clk_fpga,
  input  logic                   rst_n,
  input  dyna_pkg::dyna_inst_t   cmd,
  input  logic                   cmd_valid,
  output logic                   busy,
  output dyna_pkg::dyna_inst_t   tx_pkt,
  output logic                   tx_start,
  input  logic                   tx_done,
  output logic                   rx_arm,
  input  dyna_pkg::dyna_status_t status,
  input  logic                   status_valid,
  output dyna_pkg::dyna_rsp_t    rsp,
  output logic                   rsp_valid
);

  localparam int tmo_w = $clog2(rsp_timeout_clks + 1);

  typedef enum logic [1:0] {
    st_idle,   // Waiting for a command
    st_send,   // Sender owns the bus
    st_await   // Receiver armed, window running
  } state_t;

  state_t           state;
  logic             accept;
  logic             timed_out;
  logic [tmo_w-1:0] tmo_cnt;

  assign accept    = (state == st_idle) && cmd_valid;
  assign tx_start  = accept;  // Sender registers it, start bit follows next cycle
  assign busy      = (state != st_idle);
  assign rx_arm    = (state == st_await);
  assign timed_out = rx_arm && (tmo_cnt == tmo_w'(rsp_timeout_clks - 1));

  // Command copy, read by the sender until tx_done
  always_ff @(posedge clk_fpga) begin
    if (accept) tx_pkt <= cmd;
  end

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk_fpga or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      tmo_cnt   <= '0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        st_idle: if (accept) state <= st_send;
        st_send: begin
          if (tx_done) begin
            state   <= st_await;  // Turn the bus around
            tmo_cnt <= '0;
          end
        end
        st_await: begin
          tmo_cnt <= tmo_cnt + tmo_w'(1);
          if (status_valid || timed_out) begin
            state     <= st_idle;  // busy drops with rsp_valid
            rsp_valid <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Response merge, a status in the last window cycle wins over timeout
  always_ff @(posedge clk_fpga) begin
    if (rx_arm && status_valid) begin
      rsp.status  <= status;
      rsp.timeout <= 1'b0;
    end else if (timed_out) begin
      rsp.status  <= '0;
      rsp.timeout <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/dyna_pkg.sv ====
// Dynamixel protocol 1.0 framing only, no sync write or bulk read
// At most max_params parameter bytes per packet in either direction
`default_nettype none

package dyna_pkg;

  // ----------------------------------------
  // Packet limits
  // ----------------------------------------
  localparam int         max_params    = 6;      // Longest parameter list carried
  localparam logic [7:0] preamble_byte = 8'hFF;  // Both header bytes

  typedef logic [$clog2(max_params+1)-1:0] param_cnt_t;  // 0 to max_params
  typedef logic [max_params-1:0][7:0]      param_arr_t;  // params[0] goes first on the wire

  // Instruction codes understood by the servo
  typedef enum logic [7:0] {
    ping       = 8'h01,
    read_data  = 8'h02,
    write_data = 8'h03
  } inst_code_t;

  // ----------------------------------------
  // Status error byte
  // ----------------------------------------
  typedef struct packed {
    logic reserved;       // Bit 7, always zero on MX parts
    logic instruction;    // Undefined instruction
    logic overload;       // Load above max torque
    logic checksum;       // Servo saw a bad instruction checksum
    logic range;          // Command out of range
    logic overheating;    // Internal temperature limit
    logic angle_limit;    // Goal outside CW/CCW limits
    logic input_voltage;  // Bit 0, supply out of range
  } dyna_error_flags_t;

  // Same byte read as a raw value or as named flags
  typedef union packed {
    logic [7:0]        raw;
    dyna_error_flags_t flags;
  } dyna_error_u;

  // ----------------------------------------
  // Host side packet types
  // ----------------------------------------
  typedef struct packed {
    logic [7:0] id;
    inst_code_t inst;
    param_cnt_t param_count;  // Length byte is this plus 2
    param_arr_t params;       // Only the first param_count entries are sent
  } dyna_inst_t;

  typedef struct packed {
    logic [7:0]  id;
    dyna_error_u error;
    param_cnt_t  param_count;
    param_arr_t  params;       // Unused entries read as zero
    logic        checksum_ok;  // Local sum matched the received byte
  } dyna_status_t;

  typedef struct packed {
    dyna_status_t status;      // All zero on timeout
    logic         timeout;     // No complete status packet in the window
  } dyna_rsp_t;

endpackage

`default_nettype wire

// ==== src/dyna_status_receiver.sv ====
// 8N1 only, samples once per bit near mid-bit, no majority vote
// Deaf while rx_arm is low, lengths above max_params + 2 restart the search
`timescale 1ns/1ps
`default_nettype none

module dyna_status_receiver #(
  parameter int clks_per_bit = 868
) (
  input  logic                   clk_fpga,
  input  logic                   rst_n,
  input  logic                   rx_arm,
  input  logic                   ttl_in,
  output dyna_pkg::dyna_status_t status,
  output logic                   status_valid
);

  import dyna_pkg::*;

  localparam int cnt_w    = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  // First sample offset, sync and detect latency take 3 cycles
  localparam int half_cnt = (clks_per_bit >= 8) ? clks_per_bit / 2 - 3 : 0;

  typedef enum logic [2:0] {
    p_pre0, p_pre1, p_id, p_len, p_err, p_param, p_csum
  } parse_t;

  logic             rx_meta, rx_s;  // Two stage synchronizer
  logic             rx_busy;        // Inside a frame
  logic [3:0]       bit_cnt;        // 0 start, 1..8 data, 9 stop
  logic [cnt_w-1:0] baud_cnt;
  logic [7:0]       rx_byte;
  logic             byte_stb;       // rx_byte complete with a good stop bit
  parse_t           pstate;
  param_cnt_t       param_idx;
  logic [7:0]       csum;
  logic             len_ok;

  always_ff @(posedge clk_fpga or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= ttl_in;
      rx_s    <= rx_meta;
    end
  end

  // ----------------------------------------
  // Deserializer
  // ----------------------------------------
  always_ff @(posedge clk_fpga or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      byte_stb <= 1'b0;
    end else begin
      byte_stb <= 1'b0;
      if (!rx_arm) begin
        rx_busy <= 1'b0;                       // Own echo and noise ignored
      end else if (!rx_busy) begin
        if (!rx_s) begin                       // Falling edge, start bit
          rx_busy  <= 1'b1;
          bit_cnt  <= '0;
          baud_cnt <= cnt_w'(half_cnt);
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - cnt_w'(1);
      end else begin
        baud_cnt <= cnt_w'(clks_per_bit - 1);
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd0) begin
          if (rx_s) rx_busy <= 1'b0;           // Glitch, not a start bit
        end else if (bit_cnt == 4'd9) begin
          rx_busy  <= 1'b0;
          byte_stb <= rx_s;                    // Framing error drops the byte
        end
      end
    end
  end

  always_ff @(posedge clk_fpga) begin
    if (rx_busy && (baud_cnt == '0) && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
      rx_byte <= {rx_s, rx_byte[7:1]};       // LSB arrives first
    end
  end

  // ----------------------------------------
  // Status packet parser
  // ----------------------------------------
  assign len_ok = (rx_byte >= 8'd2) && (rx_byte <= 8'(max_params + 2));

  always_ff @(posedge clk_fpga or negedge rst_n) begin
    if (!rst_n) begin
      pstate       <= p_pre0;
      param_idx    <= '0;
      status_valid <= 1'b0;
    end else begin
      status_valid <= 1'b0;
      if (!rx_arm) begin
        pstate <= p_pre0;
      end else if (byte_stb) begin
        case (pstate)
          p_pre0: if (rx_byte == preamble_byte) pstate <= p_pre1;
          p_pre1: pstate <= (rx_byte == preamble_byte) ? p_id : p_pre0;
          p_id:   pstate <= p_len;
          p_len:  pstate <= len_ok ? p_err : p_pre0;
          p_err: begin
            param_idx <= '0;
            pstate    <= (status.param_count == '0) ? p_csum : p_param;
          end
          p_param: begin
            param_idx <= param_idx + param_cnt_t'(1);
            if (param_idx == status.param_count - param_cnt_t'(1)) pstate <= p_csum;
          end
          default: begin                       // Checksum byte ends the packet
            status_valid <= 1'b1;
            pstate       <= p_pre0;
          end
        endcase
      end
    end
  end

  // Payload capture, sum covers id, length, error and params
  always_ff @(posedge clk_fpga) begin
    if (byte_stb) begin
      case (pstate)
        p_id: begin
          status.id     <= rx_byte;
          status.params <= '0;
          csum          <= rx_byte;
        end
        p_len: begin
          status.param_count <= param_cnt_t'(rx_byte - 8'd2);
          csum               <= csum + rx_byte;
        end
        p_err: begin
          status.error.raw <= rx_byte;
          csum             <= csum + rx_byte;
        end
        p_param: begin
          status.params[param_idx] <= rx_byte;
          csum                     <= csum + rx_byte;
        end
        p_csum:  status.checksum_ok <= (rx_byte == ~csum);
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== testbench/dyna_ctrl_checker.sv ====
// Bound into dyna_ctrl, watches the host handshake and the bus direction
// All properties are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module dyna_ctrl_checker (
  input logic clk_fpga,
  input logic rst_n,
  input logic cmd_valid,
  input logic busy,
  input logic rsp_valid,
  input logic ttl_oe
);

  int fail_count = 0;  // Tally for the end of run summary

  // Response strobe is a single cycle
  rsp_pulse_a: assert property (@(posedge clk_fpga) disable iff (!rst_n)
    rsp_valid |=> !rsp_valid)
    else begin
      fail_count++;
      $error("rsp_valid high for more than one cycle");
    end

  // Bus only driven inside a transaction
  oe_busy_a: assert property (@(posedge clk_fpga) disable iff (!rst_n)
    ttl_oe |-> busy)
    else begin
      fail_count++;
      $error("ttl_oe high while busy is low");
    end

  // A frame only starts from a strobe taken while idle
  oe_start_a: assert property (@(posedge clk_fpga) disable iff (!rst_n)
    $rose(ttl_oe) |-> $past(cmd_valid && !busy))
    else begin
      fail_count++;
      $error("ttl_oe rose without an accepted cmd_valid");
    end

endmodule

bind dyna_ctrl dyna_ctrl_checker checker_i (
  .clk_fpga  (clk_fpga),
  .rst_n     (rst_n),
  .cmd_valid (cmd_valid),
  .busy      (busy),
  .rsp_valid (rsp_valid),
  .ttl_oe    (ttl_oe)
);

`default_nettype wire

// ==== testbench/tb_dyna_ctrl.sv ====
// Directed tests at 8 clocks per bit, a behavioral servo answers on ttl_in
// Bus bytes are decoded on falling edges, away from the DUT's rising edge updates
`timescale 1ns/1ps
`default_nettype none

module tb_dyna_ctrl;

  import dyna_pkg::*;

  localparam int clk_period  = 20;
  localparam int drive_dly   = 2;      // Inputs change this long after the rising edge
  localparam int bit_clks    = 8;
  localparam int tmo_clks    = 2000;
  localparam int reply_gap   = 20;     // Servo return delay in cycles
  localparam int rsp_limit   = tmo_clks + 500;
  localparam int watchdog_ns = 6 * 30 * 80 * clk_period + 100000;

  logic       clk_fpga;
  logic       rst_n;
  logic       cmd_valid;
  logic       busy;
  logic       rsp_valid;
  logic       ttl_out;
  logic       ttl_oe;
  logic       ttl_in;
  dyna_inst_t cmd;
  dyna_rsp_t  rsp;
  dyna_rsp_t  last_rsp;                // Copy taken on each rsp_valid
  logic [7:0] wire_bytes[$];           // Decoded from ttl_out
  logic [7:0] reply_params[$];         // Returned by the servo model
  logic       oe_prev   = 1'b0;
  int         oe_rises  = 0;
  int         oe_cycles = 0;
  int         rsp_count = 0;
  int         checks    = 0;
  int         errors    = 0;

  dyna_ctrl #(
    .clks_per_bit     (bit_clks),
    .rsp_timeout_clks (tmo_clks)
  ) dyna_ctrl_i (
    .clk_fpga  (clk_fpga),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .ttl_out   (ttl_out),
    .ttl_oe    (ttl_oe),
    .ttl_in    (ttl_in)
  );

  initial begin
    clk_fpga = 1'b0;
    forever #(clk_period / 2) clk_fpga = ~clk_fpga;
  end

  // ----------------------------------------
  // Monitors
  // ----------------------------------------
  always @(negedge clk_fpga) begin
    if (ttl_oe) oe_cycles++;                 // Span of bus ownership
    if (ttl_oe && !oe_prev) oe_rises++;      // One per instruction packet
    oe_prev = ttl_oe;
    if (rsp_valid) begin
      rsp_count++;
      last_rsp = rsp;
    end
  end

  initial begin : byte_decoder
    logic [9:0] frm;
    forever begin
      @(negedge clk_fpga);
      while (ttl_oe) begin                   // Half a cycle into a start bit here
        repeat (bit_clks / 2) @(negedge clk_fpga);
        for (int b = 0; b < 10; b++) begin
          frm[b] = ttl_out;                  // Mid-bit sample
          if (b < 9) repeat (bit_clks) @(negedge clk_fpga);
        end
        checks++;
        assert (frm[0] == 1'b0 && frm[9] == 1'b1) else begin
          errors++;
          $display("Framing error on ttl_out, bad start or stop bit at %0t", $time);
        end
        wire_bytes.push_back(frm[8:1]);
        repeat (bit_clks / 2) @(negedge clk_fpga);  // Into the next start bit
      end
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic tick(input int n);
    repeat (n) @(posedge clk_fpga);
    #(drive_dly);
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frm;
    frm = {1'b1, b, 1'b0};                   // Stop, data, start
    for (int i = 0; i < 10; i++) begin
      ttl_in = frm[i];
      tick(bit_clks);
    end
  endtask

  // Servo status packet, sum over id, length, error and params
  task automatic send_status(input logic [7:0] id, input logic [7:0] err, input logic corrupt);
    logic [7:0] len;
    logic [7:0] sum;
    len = 8'(reply_params.size() + 2);
    sum = id + len + err;
    send_byte(8'hFF);
    send_byte(8'hFF);
    send_byte(id);
    send_byte(len);
    send_byte(err);
    foreach (reply_params[i]) begin
      send_byte(reply_params[i]);
      sum = sum + reply_params[i];
    end
    send_byte(corrupt ? sum : ~sum);         // A sum never equals its own inverse
  endtask

  // Expected instruction packet rebuilt from the framing rules
  task automatic check_wire(input dyna_inst_t c);
    logic [7:0] exp[$];
    logic [7:0] sum;
    exp = {8'hFF, 8'hFF, c.id, 8'(c.param_count) + 8'd2, 8'(c.inst)};
    sum = exp[2] + exp[3] + exp[4];
    for (int i = 0; i < int'(c.param_count); i++) begin
      exp.push_back(c.params[i]);
      sum = sum + c.params[i];
    end
    exp.push_back(~sum);
    check_val("wire byte count", wire_bytes.size(), exp.size());
    foreach (exp[i]) begin
      if (i < wire_bytes.size()) begin
        check_val($sformatf("wire byte %0d", i), int'(wire_bytes[i]), int'(exp[i]));
      end
    end
  endtask

  function automatic dyna_inst_t make_cmd(input inst_code_t inst, input int n);
    dyna_inst_t c;
    c             = '0;
    c.id          = 8'($urandom_range(253, 1));  // 0xFE is broadcast, never answered
    c.inst        = inst;
    c.param_count = param_cnt_t'(n);
    for (int i = 0; i < n; i++) c.params[i] = 8'($urandom);
    return c;
  endfunction

  // One command, optional stray strobe, optional servo reply, wait for rsp_valid
  task automatic transact(input dyna_inst_t c, input logic reply, input logic [7:0] err,
                          input logic corrupt, input logic stray);
    int r0;
    int q0;
    int n;
    r0 = oe_rises;
    q0 = rsp_count;
    n  = 0;
    wire_bytes.delete();
    cmd       = c;
    cmd_valid = 1'b1;
    tick(1);
    cmd_valid = 1'b0;
    if (stray) begin                         // Lands in the middle of the first byte
      tick(40);
      cmd.id    = c.id + 8'd1;
      cmd_valid = 1'b1;
      tick(1);
      cmd_valid = 1'b0;
    end
    while ((oe_rises == r0 || ttl_oe) && n < 4000) begin
      tick(1);
      n++;
    end
    checks++;
    assert (n < 4000) else begin
      errors++;
      $display("Instruction packet never finished on the bus");
    end
    tick(reply_gap);                         // Decoder is done by now
    check_wire(c);
    if (reply) send_status(c.id, err, corrupt);
    n = 0;
    while (rsp_count == q0 && n < rsp_limit) begin
      tick(1);
      n++;
    end
    checks++;
    assert (rsp_count != q0) else begin
      errors++;
      $display("No rsp_valid within %0d cycles", rsp_limit);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_ping();
    dyna_inst_t c;
    c = make_cmd(ping, 0);
    reply_params = {};
    transact(c, 1'b1, 8'h00, 1'b0, 1'b0);
    check_val("rsp.status.id", int'(last_rsp.status.id), int'(c.id));
    check_val("rsp.status.checksum_ok", int'(last_rsp.status.checksum_ok), 1);
    check_val("rsp.timeout", int'(last_rsp.timeout), 0);
  endtask

  task automatic test_write();
    dyna_inst_t c;
    int         oe0;
    c   = make_cmd(write_data, 3);
    oe0 = oe_cycles;
    reply_params = {};
    transact(c, 1'b1, 8'h00, 1'b0, 1'b0);
    check_val("ttl_oe high cycles", oe_cycles - oe0, (3 + 6) * 10 * bit_clks);
    check_val("rsp.timeout", int'(last_rsp.timeout), 0);
  endtask

  task automatic test_read_error();
    dyna_inst_t c;
    c = make_cmd(read_data, 2);
    reply_params = {8'($urandom), 8'($urandom)};
    transact(c, 1'b1, 8'h0C, 1'b0, 1'b0);   // Range and overheating set
    check_val("rsp.status.param_count", int'(last_rsp.status.param_count), 2);
    check_val("rsp.status.params[0]", int'(last_rsp.status.params[0]), int'(reply_params[0]));
    check_val("rsp.status.params[1]", int'(last_rsp.status.params[1]), int'(reply_params[1]));
    check_val("rsp.status.error.raw", int'(last_rsp.status.error.raw), 32'h0C);
    check_val("error.flags.range", int'(last_rsp.status.error.flags.range), 1);
    check_val("error.flags.overheating", int'(last_rsp.status.error.flags.overheating), 1);
    check_val("error.flags.overload", int'(last_rsp.status.error.flags.overload), 0);
    check_val("rsp.status.checksum_ok", int'(last_rsp.status.checksum_ok), 1);
  endtask

  task automatic test_bad_checksum();
    reply_params = {};
    transact(make_cmd(ping, 0), 1'b1, 8'h00, 1'b1, 1'b0);
    check_val("rsp.status.checksum_ok", int'(last_rsp.status.checksum_ok), 0);
    check_val("rsp.timeout", int'(last_rsp.timeout), 0);
  endtask

  task automatic test_no_reply();
    transact(make_cmd(read_data, 2), 1'b0, 8'h00, 1'b0, 1'b0);
    check_val("rsp.timeout", int'(last_rsp.timeout), 1);
    check_val("rsp.status is zero", int'(last_rsp.status == '0), 1);
    check_val("busy", int'(busy), 0);
  endtask

  task automatic test_stray_strobe();
    int r0;
    int q0;
    r0 = oe_rises;
    q0 = rsp_count;
    reply_params = {};
    transact(make_cmd(write_data, 1), 1'b1, 8'h00, 1'b0, 1'b1);
    tick(300);                               // Room for a wrongly started second frame
    check_val("ttl_oe rises", oe_rises - r0, 1);
    check_val("rsp_valid pulses", rsp_count - q0, 1);
  endtask

  initial begin
    void'($urandom(55180));
    rst_n     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    ttl_in    = 1'b1;                        // Idle line
    tick(2);
    rst_n = 1'b1;
    tick(5);
    test_ping();
    test_write();
    test_read_error();
    test_bad_checksum();
    test_no_reply();
    test_stray_strobe();
    tick(20);
    check_val("checker assertion failures", dyna_ctrl_i.checker_i.fail_count, 0);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run did not complete", watchdog_ns);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
